// File: hw/board_params.svh
`ifndef BOARD_PARAMS_SVH
`define BOARD_PARAMS_SVH

// **********************************************************************
// Board timing and bus constants
// **********************************************************************

// Clock cycles per digit scan step of the seven-segment displays.
`define BOARD_SCAN_DIV 25000

// Clock cycles per capture of the buttons and switches.
`define BOARD_SAMPLE_DIV 250000

// Width of the APB address bus.
`define BOARD_APB_AW 8

// Display-select code that puts the raw segment bytes on the digits.
`define BOARD_DIRECT_SEL 10

`endif

// File: hw/busPkg.sv
`default_nettype none
`include "board_params.svh"

package busPkg;

   // Master to slave half of an APB transfer.
   typedef struct packed {
      logic [`BOARD_APB_AW-1:0] paddr;
      logic                     psel;
      logic                     penable;
      logic                     pwrite;
      logic [31:0]              pwdata;
   } apbRequest;

   // Slave to master half of an APB transfer.
   typedef struct packed {
      logic [31:0] prdata;
      logic        pready;
      logic        pslverr;
   } apbResponse;

   // Register map of the port block. Word aligned.
   typedef enum logic [`BOARD_APB_AW-1:0] {
      ADDR_PORTA = 8'h00,
      ADDR_PORTB = 8'h04,
      ADDR_PORTC = 8'h08,
      ADDR_PORTD = 8'h0C,
      ADDR_PORTI = 8'h10,
      ADDR_PORTJ = 8'h14,
      ADDR_COUNT = 8'h18
   } portAddress;

endpackage

`default_nettype wire

// File: hw/boardPkg.sv
`default_nettype none
`include "board_params.svh"

package boardPkg;

   // Buttons and switches as seen by the rest of the board.
   typedef struct packed {
      logic [3:0]  btn;
      logic [15:0] sw;
   } boardInputs;

   // The four writable output ports.
   typedef struct packed {
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      logic [31:0] d;
   } outputPorts;

   // Word shown on the displays. Codes not listed here show zeros.
   typedef enum logic [3:0] {
      SRC_PORTA  = 4'd0,
      SRC_PORTB  = 4'd1,
      SRC_PORTC  = 4'd2,
      SRC_PORTD  = 4'd3,
      SRC_COUNT  = 4'd4,
      SRC_PORTI  = 4'd5,
      SRC_PORTJ  = 4'd6,
      SRC_DIRECT = 4'(`BOARD_DIRECT_SEL)
   } displaySource;

   // One four-digit display. Both fields are active low, seg[7] is the dot.
   typedef struct packed {
      logic [7:0] seg;
      logic [3:0] an;
   } sevenSegment;

endpackage

`default_nettype wire

// File: hw/tickDivider.sv
`default_nettype none
`include "board_params.svh"

module tickDivider
(
   input  wire logic selected_clk,
   input  wire logic res,
   output logic      scanTick,
   output logic      sampleTick
);

   logic [31:0] scanCount;
   logic [31:0] sampleCount;

   // **********************************************************************
   // Scan tick
   // **********************************************************************

   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         scanCount <= '0;
         scanTick  <= 1'b0;
      end
      else
      begin
         scanTick <= (scanCount == 32'(`BOARD_SCAN_DIV - 1));
         if (scanCount == 32'(`BOARD_SCAN_DIV - 1))
            scanCount <= '0;
         else
            scanCount <= scanCount + 32'd1;
      end
   end

   // **********************************************************************
   // Sample tick
   // **********************************************************************

   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         sampleCount <= '0;
         sampleTick  <= 1'b0;
      end
      else
      begin
         sampleTick <= (sampleCount == 32'(`BOARD_SAMPLE_DIV - 1));
         if (sampleCount == 32'(`BOARD_SAMPLE_DIV - 1))
            sampleCount <= '0;
         else
            sampleCount <= sampleCount + 32'd1;
      end
   end

endmodule

`default_nettype wire

// File: hw/inputSampler.sv
`default_nettype none

module inputSampler
   import boardPkg::*;
(
   input  wire logic [3:0]  btn,
   input  wire logic [15:0] sw,
   input  wire logic        selected_clk,
   input  wire logic        res,
   input  wire logic        sampleTick,
   output boardInputs       sampled
);

   boardInputs syncFirst;
   boardInputs syncSecond;

   // Two flops bring the asynchronous pins into the clock domain.
   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         syncFirst  <= '0;
         syncSecond <= '0;
      end
      else
      begin
         syncFirst  <= '{btn: btn, sw: sw};
         syncSecond <= syncFirst;
      end
   end

   // The slow capture filters out contact bounce.
   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         sampled <= '0;
      end
      else if (sampleTick)
      begin
         sampled <= syncSecond;
      end
   end

endmodule

`default_nettype wire

// File: hw/portRegisters.sv
`default_nettype none

module portRegisters
   import busPkg::*, boardPkg::*;
(
   input  wire logic       selected_clk,
   input  wire logic       res,
   input  wire apbRequest  request,
   output apbResponse      response,
   input  wire boardInputs sampled,
   output outputPorts      ports,
   output logic [31:0]     cycleCount
);

   portAddress  address;
   logic        access;
   logic        mapped;
   logic        readOnly;
   logic [31:0] readData;
   logic [31:0] portI;
   logic [31:0] portJ;

   assign address = portAddress'(request.paddr);
   assign access  = request.psel & request.penable;
   assign portI   = {28'd0, sampled.btn};
   assign portJ   = {16'd0, sampled.sw};

   // **********************************************************************
   // Address decode and read mux
   // **********************************************************************

   always_comb
   begin
      readData = '0;
      mapped   = 1'b1;
      readOnly = 1'b0;
      case (address)
         ADDR_PORTA: readData = ports.a;
         ADDR_PORTB: readData = ports.b;
         ADDR_PORTC: readData = ports.c;
         ADDR_PORTD: readData = ports.d;
         ADDR_PORTI:
         begin
            readData = portI;
            readOnly = 1'b1;
         end
         ADDR_PORTJ:
         begin
            readData = portJ;
            readOnly = 1'b1;
         end
         ADDR_COUNT:
         begin
            readData = cycleCount;
            readOnly = 1'b1;
         end
         default: mapped = 1'b0;
      endcase
   end

   // Transfers always complete in the access cycle.
   assign response.pready  = 1'b1;
   assign response.pslverr = access & (~mapped | (request.pwrite & readOnly));
   assign response.prdata  = (access & ~request.pwrite) ? readData : '0;

   // **********************************************************************
   // Writable ports and cycle counter
   // **********************************************************************

   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         ports <= '0;
      end
      else if (access && request.pwrite)
      begin
         case (address)
            ADDR_PORTA: ports.a <= request.pwdata;
            ADDR_PORTB: ports.b <= request.pwdata;
            ADDR_PORTC: ports.c <= request.pwdata;
            ADDR_PORTD: ports.d <= request.pwdata;
            default: ;
         endcase
      end
   end

   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
         cycleCount <= '0;
      else
         cycleCount <= cycleCount + 32'd1;
   end

endmodule

`default_nettype wire

// File: hw/segmentDisplay.sv
`default_nettype none

module segmentDisplay
   import boardPkg::*;
(
   input  wire logic         selected_clk,
   input  wire logic         res,
   input  wire logic         scanTick,
   input  wire displaySource source,
   input  wire outputPorts   ports,
   input  wire logic [31:0]  cycleCount,
   input  wire boardInputs   sampled,
   output sevenSegment       low,
   output sevenSegment       high
);

   logic [1:0]  digit;
   logic [31:0] word;
   logic [15:0] lowHalf;
   logic [15:0] highHalf;
   logic [3:0]  lowNibble;
   logic [3:0]  highNibble;
   logic [3:0]  anodes;

   // Active-low segments gfedcba with the decimal point dark.
   function automatic logic [7:0] hexSegments(input logic [3:0] value);
      logic [7:0] pattern;
      case (value)
         4'h0: pattern = 8'hC0;
         4'h1: pattern = 8'hF9;
         4'h2: pattern = 8'hA4;
         4'h3: pattern = 8'hB0;
         4'h4: pattern = 8'h99;
         4'h5: pattern = 8'h92;
         4'h6: pattern = 8'h82;
         4'h7: pattern = 8'hF8;
         4'h8: pattern = 8'h80;
         4'h9: pattern = 8'h90;
         4'hA: pattern = 8'h88;
         4'hB: pattern = 8'h83;
         4'hC: pattern = 8'hC6;
         4'hD: pattern = 8'hA1;
         4'hE: pattern = 8'h86;
         default: pattern = 8'h8E;
      endcase
      return pattern;
   endfunction

   // **********************************************************************
   // Digit scanning
   // **********************************************************************

   // One counter drives both displays, so their digits stay in step.
   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
         digit <= 2'd0;
      else if (scanTick)
         digit <= digit + 2'd1;
   end

   assign anodes = ~(4'b0001 << digit);

   // **********************************************************************
   // Source selection and segment drive
   // **********************************************************************

   always_comb
   begin
      case (source)
         SRC_PORTA: word = ports.a;
         SRC_PORTB: word = ports.b;
         SRC_PORTC: word = ports.c;
         SRC_PORTD: word = ports.d;
         SRC_COUNT: word = cycleCount;
         SRC_PORTI: word = {28'd0, sampled.btn};
         SRC_PORTJ: word = {16'd0, sampled.sw};
         default:   word = '0;
      endcase
   end

   assign lowHalf    = word[15:0];
   assign highHalf   = word[31:16];
   assign lowNibble  = lowHalf[{digit, 2'b00} +: 4];
   assign highNibble = highHalf[{digit, 2'b00} +: 4];

   always_comb
   begin
      low.an  = anodes;
      high.an = anodes;
      if (source == SRC_DIRECT)
      begin
         // Ports C and D hold one raw segment byte per digit.
         low.seg  = ports.c[{digit, 3'b000} +: 8];
         high.seg = ports.d[{digit, 3'b000} +: 8];
      end
      else
      begin
         low.seg  = hexSegments(lowNibble);
         high.seg = hexSegments(highNibble);
      end
   end

endmodule

`default_nettype wire

// File: hw/boardTop.sv
`default_nettype none

module boardTop
   import busPkg::*, boardPkg::*;
(
   input  wire logic        selected_clk,
   input  wire logic        res,
   input  wire logic [3:0]  btn,
   input  wire logic [15:0] sw,
   input  wire apbRequest   request,
   output apbResponse       response,
   output logic [15:0]      led,
   output logic [7:0]       segL,
   output logic [3:0]       anL,
   output logic [7:0]       segH,
   output logic [3:0]       anH
);

   logic        scanTick;
   logic        sampleTick;
   boardInputs  sampled;
   outputPorts  ports;
   logic [31:0] cycleCount;
   sevenSegment low;
   sevenSegment high;

   // **********************************************************************
   // Clock enables and input capture
   // **********************************************************************

   tickDivider ticks
   (
      .selected_clk (selected_clk),
      .res          (res),
      .scanTick     (scanTick),
      .sampleTick   (sampleTick)
   );

   inputSampler sampler
   (
      .btn          (btn),
      .sw           (sw),
      .selected_clk (selected_clk),
      .res          (res),
      .sampleTick   (sampleTick),
      .sampled      (sampled)
   );

   // **********************************************************************
   // Bus registers and display
   // **********************************************************************

   portRegisters registers
   (
      .selected_clk (selected_clk),
      .res          (res),
      .request      (request),
      .response     (response),
      .sampled      (sampled),
      .ports        (ports),
      .cycleCount   (cycleCount)
   );

   // Switches 7 to 4 pick the displayed word.
   segmentDisplay display
   (
      .selected_clk (selected_clk),
      .res          (res),
      .scanTick     (scanTick),
      .source       (displaySource'(sampled.sw[7:4])),
      .ports        (ports),
      .cycleCount   (cycleCount),
      .sampled      (sampled),
      .low          (low),
      .high         (high)
   );

   assign led  = ports.b[15:0];
   assign segL = low.seg;
   assign anL  = low.an;
   assign segH = high.seg;
   assign anH  = high.an;

endmodule

`default_nettype wire

// File: bench/clockSource.sv
`default_nettype none

module clockSource
(
   output logic clk,
   output logic res
);

   initial
   begin
      clk = 1'b0;
      forever
         #50 clk = ~clk;
   end

   // Reset covers the first ten rising edges and drops just after the tenth.
   initial
   begin
      res = 1'b1;
      repeat (10) @(posedge clk);
      #10 res = 1'b0;
   end

endmodule

`default_nettype wire

// File: bench/boardBench.sv
`default_nettype none
`include "board_params.svh"

module boardBench
   import busPkg::*, boardPkg::*;
();

   // Two full sample waits, then per display source one sample delay and
   // about eight scan steps, with room to spare.
   localparam int cycleLimit = 12 * `BOARD_SAMPLE_DIV + 80 * `BOARD_SCAN_DIV + 2000;

   // Active-low digit patterns gfedcba with the dot dark.
   localparam logic [7:0] hexTable [16] = '{
      8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82, 8'hF8,
      8'h80, 8'h90, 8'h88, 8'h83, 8'hC6, 8'hA1, 8'h86, 8'h8E
   };

   logic        clk;
   logic        res;
   logic [3:0]  btn;
   logic [15:0] sw;
   apbRequest   request;
   apbResponse  response;
   logic [15:0] led;
   logic [7:0]  segL;
   logic [3:0]  anL;
   logic [7:0]  segH;
   logic [3:0]  anH;

   int          errorCount = 0;
   int          checkCount = 0;
   int          elapsedCycles = 0;
   logic [31:0] expectedCount = '0;
   logic [31:0] randomState = 32'h0f8a8a18;

   clockSource clockGen
   (
      .clk (clk),
      .res (res)
   );

   boardTop UUT
   (
      .selected_clk (clk),
      .res          (res),
      .btn          (btn),
      .sw           (sw),
      .request      (request),
      .response     (response),
      .led          (led),
      .segL         (segL),
      .anL          (anL),
      .segH         (segH),
      .anH          (anH)
   );

   // The DUT counter starts at zero and steps on every edge out of reset.
   always @(posedge clk)
   begin
      if (!res)
         expectedCount <= expectedCount + 32'd1;
   end

   always @(posedge clk)
   begin
      elapsedCycles = elapsedCycles + 1;
      if (elapsedCycles > cycleLimit)
      begin
         $display("Timeout: the tests did not finish within %0d cycles", cycleLimit);
         $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   // **********************************************************************
   // Helpers
   // **********************************************************************

   task automatic nextCycle();
      @(posedge clk);
      #10;
   endtask

   task automatic checkWord(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
      checkCount++;
      if (actual !== expected)
      begin
         errorCount++;
         $display("Fail at %0t: %s is %h, expected %h", $time, name, actual, expected);
      end
   endtask

   function automatic logic [31:0] xorshift(input logic [31:0] value);
      logic [31:0] x;
      x = value;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic drawRandom(output logic [31:0] value);
      randomState = xorshift(randomState);
      value = randomState;
   endtask

   function automatic logic [3:0] activeAnodes(input int k);
      logic [3:0] pattern;
      case (k)
         0:       pattern = 4'b1110;
         1:       pattern = 4'b1101;
         2:       pattern = 4'b1011;
         default: pattern = 4'b0111;
      endcase
      return pattern;
   endfunction

   // Both tasks start and end 10 units after a rising edge.
   task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data, output logic err);
      request.paddr   = addr;
      request.pwrite  = 1'b1;
      request.pwdata  = data;
      request.psel    = 1'b1;
      request.penable = 1'b0;
      nextCycle();
      request.penable = 1'b1;
      #40;
      err = response.pslverr;
      nextCycle();
      request.psel    = 1'b0;
      request.penable = 1'b0;
      request.pwrite  = 1'b0;
   endtask

   task automatic apbRead(input logic [7:0] addr, output logic [31:0] data, output logic err);
      request.paddr   = addr;
      request.pwrite  = 1'b0;
      request.psel    = 1'b1;
      request.penable = 1'b0;
      nextCycle();
      request.penable = 1'b1;
      #40;
      data = response.prdata;
      err  = response.pslverr;
      if (response.pready !== 1'b1)
      begin
         errorCount++;
         $display("The DUT did not complete a read in its access cycle");
      end
      nextCycle();
      request.psel    = 1'b0;
      request.penable = 1'b0;
   endtask

   // New pins with the source code in switch bits 7 to 4, held until port J shows them.
   task automatic selectSource(input logic [3:0] code);
      logic [31:0] pins;
      logic [31:0] data;
      logic        err;
      int          polls;
      drawRandom(pins);
      btn   = pins[19:16];
      sw    = {pins[15:8], code, pins[3:0]};
      polls = 0;
      apbRead(ADDR_PORTJ, data, err);
      while (data !== {16'd0, sw} && polls < `BOARD_SAMPLE_DIV + 4)
      begin
         apbRead(ADDR_PORTJ, data, err);
         polls++;
      end
      if (data !== {16'd0, sw})
      begin
         errorCount++;
         $display("The switch setting did not reach port J within %0d reads", polls);
      end
   endtask

   task automatic waitDigit(input int k);
      int waited;
      waited = 0;
      while ((anL !== activeAnodes(k) || anH !== activeAnodes(k))
             && waited < 4 * `BOARD_SCAN_DIV + 8)
      begin
         nextCycle();
         waited++;
      end
      if (anL !== activeAnodes(k) || anH !== activeAnodes(k))
      begin
         errorCount++;
         $display("Digit %0d never became active on both displays", k);
      end
   endtask

   function automatic logic [31:0] shownWord(input logic [3:0] code,
                                             input logic [31:0] portValue);
      logic [31:0] word;
      case (code)
         SRC_PORTA, SRC_PORTB, SRC_PORTC, SRC_PORTD: word = portValue;
         SRC_COUNT: word = expectedCount;
         SRC_PORTI: word = {28'd0, btn};
         SRC_PORTJ: word = {16'd0, sw};
         default:   word = '0;
      endcase
      return word;
   endfunction

   // **********************************************************************
   // Directed tests
   // **********************************************************************

   task automatic resetDefaults();
      logic [31:0] data;
      logic        err;
      checkWord("anL", 32'(anL), 32'hE);
      checkWord("anH", 32'(anH), 32'hE);
      checkWord("led", 32'(led), 32'h0);
      checkWord("pslverr", 32'(response.pslverr), 32'h0);
      for (int i = 0; i < 4; i++)
      begin
         apbRead(8'(i * 4), data, err);
         checkWord($sformatf("prdata of port %0d", i), data, 32'h0);
         checkWord("pslverr", 32'(err), 32'h0);
      end
   endtask

   task automatic portReadback();
      logic [31:0] written [4];
      logic [31:0] data;
      logic        err;
      for (int i = 0; i < 4; i++)
      begin
         drawRandom(written[i]);
         apbWrite(8'(i * 4), written[i], err);
         checkWord("pslverr", 32'(err), 32'h0);
         if (i == 1)
            checkWord("led", 32'(led), 32'(written[1][15:0]));
      end
      for (int i = 0; i < 4; i++)
      begin
         apbRead(8'(i * 4), data, err);
         checkWord($sformatf("prdata of port %0d", i), data, written[i]);
         checkWord("pslverr", 32'(err), 32'h0);
      end
   endtask

   task automatic inputsAndCounter();
      logic [31:0] pins;
      logic [31:0] data;
      logic [31:0] first;
      logic [31:0] second;
      logic        err;
      drawRandom(pins);
      btn = pins[19:16];
      sw  = pins[15:0];
      repeat (2 * `BOARD_SAMPLE_DIV) nextCycle();
      apbRead(ADDR_PORTI, data, err);
      checkWord("port I", data, {28'd0, btn});
      checkWord("pslverr", 32'(err), 32'h0);
      apbRead(ADDR_PORTJ, data, err);
      checkWord("port J", data, {16'd0, sw});
      checkWord("pslverr", 32'(err), 32'h0);
      // The access cycles of these two reads lie seven cycles apart.
      apbRead(ADDR_COUNT, first, err);
      repeat (5) nextCycle();
      apbRead(ADDR_COUNT, second, err);
      checkWord("count difference", second - first, 32'd7);
   endtask

   task automatic busErrors();
      logic [31:0] value;
      logic [31:0] data;
      logic        err;
      apbRead(8'h1C, data, err);
      checkWord("prdata of 0x1C", data, 32'h0);
      checkWord("pslverr", 32'(err), 32'h1);
      apbRead(8'h81, data, err);
      checkWord("prdata of 0x81", data, 32'h0);
      checkWord("pslverr", 32'(err), 32'h1);
      drawRandom(value);
      apbWrite(8'h20, value, err);
      checkWord("pslverr", 32'(err), 32'h1);
      apbWrite(ADDR_PORTI, value, err);
      checkWord("pslverr", 32'(err), 32'h1);
      apbRead(ADDR_PORTI, data, err);
      checkWord("port I", data, {28'd0, btn});
      apbWrite(ADDR_PORTJ, value, err);
      checkWord("pslverr", 32'(err), 32'h1);
      apbRead(ADDR_PORTJ, data, err);
      checkWord("port J", data, {16'd0, sw});
      apbWrite(ADDR_COUNT, value, err);
      checkWord("pslverr", 32'(err), 32'h1);
      apbRead(ADDR_COUNT, data, err);
      // The read holds the count of its access cycle, one edge back.
      checkWord("count", data, expectedCount - 32'd1);
   endtask

   task automatic hexDisplay();
      logic [31:0] value;
      logic [31:0] word;
      logic [3:0]  code;
      logic        err;
      for (int i = 0; i < 8; i++)
      begin
         // Code 12 is not a source and shows zeros.
         code = (i == 7) ? 4'd12 : 4'(i);
         drawRandom(value);
         if (i < 4)
            apbWrite(8'(i * 4), value, err);
         selectSource(code);
         for (int k = 0; k < 4; k++)
         begin
            waitDigit(k);
            word = shownWord(code, value);
            checkWord($sformatf("segL source %0d digit %0d", code, k), 32'(segL),
                      32'(hexTable[word[k * 4 +: 4]]));
            checkWord($sformatf("segH source %0d digit %0d", code, k), 32'(segH),
                      32'(hexTable[word[16 + k * 4 +: 4]]));
         end
      end
   endtask

   task automatic directSegments();
      logic [31:0] portC;
      logic [31:0] portD;
      logic        err;
      drawRandom(portC);
      drawRandom(portD);
      apbWrite(ADDR_PORTC, portC, err);
      apbWrite(ADDR_PORTD, portD, err);
      selectSource(4'(`BOARD_DIRECT_SEL));
      for (int k = 0; k < 4; k++)
      begin
         waitDigit(k);
         checkWord($sformatf("segL direct digit %0d", k), 32'(segL), 32'(portC[k * 8 +: 8]));
         checkWord($sformatf("segH direct digit %0d", k), 32'(segH), 32'(portD[k * 8 +: 8]));
      end
   endtask

   initial
   begin
      request = '0;
      btn     = '0;
      sw      = '0;
      @(negedge res);
      nextCycle();
      resetDefaults();
      portReadback();
      inputsAndCounter();
      busErrors();
      hexDisplay();
      directSegments();
      $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
      if (errorCount == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: list.f
+incdir+hw
hw/busPkg.sv
hw/boardPkg.sv
hw/tickDivider.sv
hw/inputSampler.sv
hw/portRegisters.sv
hw/segmentDisplay.sv
hw/boardTop.sv
bench/clockSource.sv
bench/boardBench.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the board testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

if ! verilator --binary -f list.f --top-module boardBench -Mdir "$buildDir" -o boardSim; then
   echo "Verilator build failed"
   exit 1
fi

"./$buildDir/boardSim" > "$logFile" 2>&1
status=$?
cat "$logFile"
if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qx "SIMULATION PASSED" "$logFile"; then
   exit 0
else
   echo "Pass message not found in $logFile"
   exit 1
fi
